// ==== memStage_consts.svh ====
`ifndef MEMSTAGE_CONSTS_SVH
`define MEMSTAGE_CONSTS_SVH

////////////////////////////////////////////////////////////
// Memory stage sizes
////////////////////////////////////////////////////////////

// One data word per lane
`define DATA_W 32

// Two lanes side by side, lane 1 in the high half
`define LANES_W 64

// Byte-addressed data memory
`define MEM_BYTES 128

// Byte address inside the memory, wraps at MEM_BYTES
`define MEM_AW 7

`endif

// ==== memStagePkg.sv ====
`include "memStage_consts.svh"

package memStagePkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	typedef logic [`DATA_W-1:0]  word_t;     // One lane word
	typedef logic [`LANES_W-1:0] laneBus_t;  // Both lanes, lane 1 on top
	typedef logic [`MEM_AW-1:0]  memAddr_t;  // Byte address, wraps

	// Which lane drives a read or a write
	typedef enum logic [1:0] {
		LANE_NONE = 2'b00,
		LANE_0    = 2'b01,
		LANE_1    = 2'b10,
		LANE_BOTH = 2'b11   // Refused, flags an error
	} laneCode_e;

	////////////////////////////////////////////////////////////
	// Stage buses
	////////////////////////////////////////////////////////////

	// Single request into the memory after lane decode
	typedef struct packed {
		logic     rd;
		logic     wr;
		logic     lane;
		memAddr_t addr;
		word_t    wdata;
	} memReq_t;

	// Loaded word on its way to write-back
	typedef struct packed {
		logic  valid;
		logic  lane;
		word_t data;
	} wbOut_t;

endpackage

// ==== memLaneSelect.sv ====
`include "memStage_consts.svh"

module memLaneSelect import memStagePkg::*; (
	input  laneBus_t  addr_i,
	input  laneBus_t  wdata_i,
	input  laneCode_e memRead_i,
	input  laneCode_e memWrite_i,
	output memReq_t   req_o,
	output logic      illegalReq_o
);

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Pick one half of a two-lane bus
	function automatic word_t laneHalf(input laneBus_t bus, input logic lane);
		word_t half;
		if (lane)
			half = bus[`LANES_W-1 -: `DATA_W];   // Lane 1
		else
			half = bus[`DATA_W-1:0];
		return half;
	endfunction

	// Only a single named lane starts an access
	function automatic logic codeActive(input laneCode_e code);
		return (code == LANE_0) || (code == LANE_1);
	endfunction

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////

	logic  rdGo;
	logic  wrGo;
	logic  rdLane;
	logic  wrLane;
	logic  reqLane;
	word_t addrHalf;

	assign rdGo = codeActive(memRead_i);
	assign wrGo = codeActive(memWrite_i);

	assign rdLane = (memRead_i == LANE_1);
	assign wrLane = (memWrite_i == LANE_1);

	// A live read claims the address lane
	assign reqLane = rdGo ? rdLane : wrLane;

	assign addrHalf = laneHalf(addr_i, reqLane);

	////////////////////////////////////////////////////////////
	// Request out
	////////////////////////////////////////////////////////////

	always_comb begin
		req_o       = '0;
		req_o.rd    = rdGo;
		req_o.wr    = wrGo;
		req_o.lane  = reqLane;
		req_o.addr  = addrHalf[`MEM_AW-1:0];     // Upper address bits ignored
		req_o.wdata = laneHalf(wdata_i, wrLane); // Data always from write lane
	end

	// Both lanes at once on either code
	assign illegalReq_o = (memRead_i == LANE_BOTH) || (memWrite_i == LANE_BOTH);

endmodule

// ==== dataMem.sv ====
`include "memStage_consts.svh"

module dataMem import memStagePkg::*; (
	input  logic    clk_i,
	input  logic    rstN_i,
	input  memReq_t req_i,
	output word_t   rdata_o
);

	localparam int BYTE_W     = 8;
	localparam int WORD_BYTES = `DATA_W / BYTE_W;

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	logic [BYTE_W-1:0] mem [`MEM_BYTES];

	// Address of each byte of the word, lowest first
	memAddr_t          byteAddr [WORD_BYTES];

	// Write word split into bytes, little-endian
	logic [BYTE_W-1:0] wrByte   [WORD_BYTES];

	// Bytes seen at the read address
	logic [BYTE_W-1:0] rdByte   [WORD_BYTES];

	////////////////////////////////////////////////////////////
	// Address and byte split
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int k = 0; k < WORD_BYTES; k++) begin
			byteAddr[k] = req_i.addr + memAddr_t'(k);   // Wraps at the top
			wrByte[k]   = req_i.wdata[k*BYTE_W +: BYTE_W];
		end
	end

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////

	// Reset wipes every byte
	always_ff @(posedge clk_i) begin
		if (!rstN_i) begin
			for (int i = 0; i < `MEM_BYTES; i++) begin
				mem[i] <= '0;
			end
		end else if (req_i.wr) begin
			for (int k = 0; k < WORD_BYTES; k++) begin
				mem[byteAddr[k]] <= wrByte[k];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////

	// Combinational, sees contents before this edge's write
	always_comb begin
		for (int k = 0; k < WORD_BYTES; k++) begin
			rdByte[k] = mem[byteAddr[k]];
		end
	end

	// Low address byte lands in the low bits
	always_comb begin
		rdata_o = '0;
		for (int k = 0; k < WORD_BYTES; k++) begin
			rdata_o[k*BYTE_W +: BYTE_W] = rdByte[k];
		end
	end

endmodule

// ==== memWbReg.sv ====
module memWbReg import memStagePkg::*; (
	input  logic   clk_i,
	input  logic   rstN_i,
	input  logic   rd_i,
	input  logic   lane_i,
	input  word_t  rdata_i,
	input  logic   illegal_i,
	output wbOut_t wb_o,
	output logic   illegal_o
);

	////////////////////////////////////////////////////////////
	// Write-back register
	////////////////////////////////////////////////////////////

	wbOut_t wbQ;
	logic   illegalQ;

	// Valid and lane follow every cycle
	always_ff @(posedge clk_i) begin
		if (!rstN_i) begin
			wbQ.valid <= 1'b0;
			wbQ.lane  <= 1'b0;
		end else begin
			wbQ.valid <= rd_i;
			wbQ.lane  <= lane_i;
		end
	end

	// Data only moves on a read, otherwise held
	always_ff @(posedge clk_i) begin
		if (!rstN_i) begin
			wbQ.data <= '0;
		end else if (rd_i) begin
			wbQ.data <= rdata_i;
		end
	end

	////////////////////////////////////////////////////////////
	// Error flag
	////////////////////////////////////////////////////////////

	// One cycle pulse per refused code
	always_ff @(posedge clk_i) begin
		if (!rstN_i) begin
			illegalQ <= 1'b0;
		end else begin
			illegalQ <= illegal_i;
		end
	end

	assign wb_o      = wbQ;
	assign illegal_o = illegalQ;

endmodule

// ==== memStageTop.sv ====
module memStageTop import memStagePkg::*; (
	input  logic      clk_i,
	input  logic      rstN_i,
	input  laneBus_t  addr_i,
	input  laneBus_t  wdata_i,
	input  laneCode_e memRead_i,
	input  laneCode_e memWrite_i,
	output wbOut_t    wb_o,
	output logic      illegal_o
);

	////////////////////////////////////////////////////////////
	// Internal wiring
	////////////////////////////////////////////////////////////

	memReq_t req;          // Decoded single-lane request
	word_t   rdata;        // Combinational load data
	logic    illegalReq;   // Refused lane code, unregistered

	////////////////////////////////////////////////////////////
	// Lane decode
	////////////////////////////////////////////////////////////

	memLaneSelect uLaneSelect (
		.addr_i       (addr_i),
		.wdata_i      (wdata_i),
		.memRead_i    (memRead_i),
		.memWrite_i   (memWrite_i),
		.req_o        (req),
		.illegalReq_o (illegalReq)
	);

	////////////////////////////////////////////////////////////
	// Data memory
	////////////////////////////////////////////////////////////

	dataMem uDataMem (
		.clk_i   (clk_i),
		.rstN_i  (rstN_i),
		.req_i   (req),
		.rdata_o (rdata)
	);

	////////////////////////////////////////////////////////////
	// To write-back
	////////////////////////////////////////////////////////////

	memWbReg uWbReg (
		.clk_i     (clk_i),
		.rstN_i    (rstN_i),
		.rd_i      (req.rd),
		.lane_i    (req.lane),
		.rdata_i   (rdata),
		.illegal_i (illegalReq),
		.wb_o      (wb_o),
		.illegal_o (illegal_o)
	);

endmodule

// ==== memStage_assertions.sv ====
module memStage_assertions import memStagePkg::*; (
	input logic      clk_i,
	input logic      rstN_i,
	input laneCode_e memRead_i,
	input laneCode_e memWrite_i,
	input wbOut_t    wb_i,
	input logic      illegal_i
);

	int failCount = 0;   // Read by the testbench at the end

	logic readCode;
	logic bothCode;

	assign readCode = (memRead_i == LANE_0) || (memRead_i == LANE_1);
	assign bothCode = (memRead_i == LANE_BOTH) || (memWrite_i == LANE_BOTH);

	////////////////////////////////////////////////////////////
	// Error pulse
	////////////////////////////////////////////////////////////

	// A second high cycle needs a fresh refused code
	illegalPulse: assert property (@(posedge clk_i) disable iff (!rstN_i)
		illegal_i |=> (!illegal_i || $past(bothCode)))
	else begin
		failCount++;
		$error("illegal_o stayed high without a new LANE_BOTH code");
	end

	////////////////////////////////////////////////////////////
	// Write-back valid and reset
	////////////////////////////////////////////////////////////

	validFollowsRead: assert property (@(posedge clk_i) disable iff (!rstN_i)
		$past(rstN_i) |-> (wb_i.valid == $past(readCode)))
	else begin
		failCount++;
		$error("wb_o.valid does not follow the read code by one cycle");
	end

	resetClears: assert property (@(posedge clk_i)
		!rstN_i |=> (!wb_i.valid && !illegal_i))   // Outputs quiet after reset
	else begin
		failCount++;
		$error("outputs not low in the cycle after reset");
	end

endmodule

bind memStageTop memStage_assertions uAssertions (
	.clk_i      (clk_i),
	.rstN_i     (rstN_i),
	.memRead_i  (memRead_i),
	.memWrite_i (memWrite_i),
	.wb_i       (wb_o),
	.illegal_i  (illegal_o)
);

// ==== memStage_tb.sv ====
`include "memStage_consts.svh"

module memStage_tb import memStagePkg::*; ();

	localparam int RESET_CYCLES = 5;

	typedef struct packed {
		laneCode_e rd;
		laneCode_e wr;
		laneBus_t  addr;
		laneBus_t  wdata;
	} opEntry_t;

	typedef struct packed {
		wbOut_t wb;
		logic   illegal;
	} expect_t;

	logic      clk;
	logic      rstN;
	laneBus_t  addr;
	laneBus_t  wdata;
	laneCode_e memRead;
	laneCode_e memWrite;
	wbOut_t    wbOut;
	logic      illegal;

	opEntry_t    ops [$];
	string       opNames [$];
	logic [7:0]  refMem [`MEM_BYTES];   // Byte model of the memory
	word_t       heldData;
	logic [31:0] lfsrState = 32'ha06f562e;
	int          errorCount = 0;
	int          checkCount = 0;
	int          cycles = 0;
	int          cycleLimit = 0;

	memStageTop uut (
		.clk_i      (clk),
		.rstN_i     (rstN),
		.addr_i     (addr),
		.wdata_i    (wdata),
		.memRead_i  (memRead),
		.memWrite_i (memWrite),
		.wb_o       (wbOut),
		.illegal_o  (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("timeout after %0d cycles, the operation table did not finish", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Random filler
	////////////////////////////////////////////////////////////

	function automatic logic lfsrStep();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit)
			lfsrState = lfsrState ^ 32'h80200003;   // x^32+x^22+x^2+x+1
		return outBit;
	endfunction

	function automatic word_t randWord();
		word_t w;
		for (int b = 0; b < `DATA_W; b++)
			w[b] = lfsrStep();   // One step per bit
		return w;
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Little-endian, byte addresses wrap at the top
	function automatic word_t modelRead(input memAddr_t a);
		word_t w;
		for (int k = 0; k < 4; k++)
			w[k*8 +: 8] = refMem[memAddr_t'(a + memAddr_t'(k))];
		return w;
	endfunction

	task automatic modelWrite(input memAddr_t a, input word_t d);
		for (int k = 0; k < 4; k++)
			refMem[memAddr_t'(a + memAddr_t'(k))] = d[k*8 +: 8];
	endtask

	// Expected outputs one cycle after the op, then apply its write
	task automatic predictOp(input opEntry_t op, output expect_t e);
		logic     rdOk;
		logic     wrOk;
		logic     lane;
		word_t    addrHalf;
		word_t    dataHalf;
		memAddr_t a;
		rdOk = (op.rd == LANE_0) || (op.rd == LANE_1);
		wrOk = (op.wr == LANE_0) || (op.wr == LANE_1);
		lane = rdOk ? (op.rd == LANE_1) : (op.wr == LANE_1);   // Read lane owns the address
		addrHalf = lane ? op.addr[`LANES_W-1 -: `DATA_W] : op.addr[`DATA_W-1:0];
		dataHalf = (op.wr == LANE_1) ? op.wdata[`LANES_W-1 -: `DATA_W] : op.wdata[`DATA_W-1:0];
		a = addrHalf[`MEM_AW-1:0];
		if (rdOk)
			heldData = modelRead(a);   // Old contents, before this write
		e.wb.valid = rdOk;
		e.wb.lane = lane;
		e.wb.data = heldData;
		e.illegal = (op.rd == LANE_BOTH) || (op.wr == LANE_BOTH);
		if (wrOk)
			modelWrite(a, dataHalf);
	endtask

	////////////////////////////////////////////////////////////
	// Table, drive and check
	////////////////////////////////////////////////////////////

	task automatic addOp(input string name, input laneCode_e rd, input laneCode_e wr,
			input word_t addr1, input word_t addr0, input word_t data1, input word_t data0);
		opEntry_t e;
		e.rd = rd;
		e.wr = wr;
		e.addr = {addr1, addr0};
		e.wdata = {data1, data0};
		ops.push_back(e);
		opNames.push_back(name);
	endtask

	task automatic buildTable();
		word_t a;
		// name, read code, write code, addr lane 1, addr lane 0, data lane 1, data lane 0
		addOp("resetRd0", LANE_0, LANE_NONE, randWord(), 32'h10, randWord(), randWord());
		addOp("resetRd1", LANE_1, LANE_NONE, 32'h7d, randWord(), randWord(), randWord());
		addOp("wrLane0", LANE_NONE, LANE_0, 32'h24, 32'h20, 32'h0bad0bad, 32'hdeadbeef);
		addOp("rdLane0", LANE_0, LANE_NONE, 32'h60, 32'h20, randWord(), randWord());
		addOp("wrLane1", LANE_NONE, LANE_1, 32'h1c0, 32'h44, 32'hcafef00d, 32'h12345678);
		addOp("rdLane1", LANE_1, LANE_NONE, 32'h40, 32'h20, randWord(), randWord());
		addOp("wrWrap", LANE_NONE, LANE_0, randWord(), 32'h7e, randWord(), 32'h44332211);
		addOp("rdWrap126", LANE_0, LANE_NONE, randWord(), 32'h7e, randWord(), randWord());
		addOp("rdWrap0", LANE_0, LANE_NONE, randWord(), 32'h00, randWord(), randWord());
		addOp("rdWrap125", LANE_1, LANE_NONE, 32'h7d, randWord(), randWord(), randWord());
		addOp("wrBothCode", LANE_NONE, LANE_BOTH, 32'h20, 32'h20, randWord(), randWord());
		addOp("rdAfterWrBoth", LANE_0, LANE_NONE, randWord(), 32'h20, randWord(), randWord());
		addOp("rdBothCode", LANE_BOTH, LANE_NONE, 32'h40, 32'h20, randWord(), randWord());
		addOp("bothBoth", LANE_BOTH, LANE_BOTH, 32'h40, 32'h40, randWord(), randWord());
		addOp("rdAfterBoth", LANE_1, LANE_NONE, 32'h40, randWord(), randWord(), randWord());
		addOp("rdWrSame", LANE_0, LANE_0, randWord(), 32'h20, randWord(), 32'h5a5aa5a5);
		addOp("idle0", LANE_NONE, LANE_NONE, randWord(), randWord(), randWord(), randWord());
		addOp("idle1", LANE_NONE, LANE_NONE, randWord(), randWord(), randWord(), randWord());
		addOp("rdNewWord", LANE_0, LANE_NONE, randWord(), 32'h20, randWord(), randWord());
		addOp("rdWrMixed", LANE_1, LANE_0, 32'h40, 32'h60, randWord(), 32'h0f0f0f0f);
		addOp("rdMixed", LANE_1, LANE_NONE, 32'h40, randWord(), randWord(), randWord());
		for (int j = 0; j < 6; j++) begin
			a = randWord();
			addOp($sformatf("rndWr%0d", j), LANE_NONE, LANE_0,
				randWord(), a, randWord(), randWord());
			addOp($sformatf("rndRd%0d", j), LANE_1, LANE_NONE,
				a, randWord(), randWord(), randWord());
		end
	endtask

	task automatic driveOp(input opEntry_t op);
		memRead <= op.rd;
		memWrite <= op.wr;
		addr <= op.addr;
		wdata <= op.wdata;
	endtask

	task automatic checkValue(input string name, input string field,
			input logic [63:0] expVal, input logic [63:0] actVal);
		checkCount++;
		if (expVal !== actVal) begin
			errorCount++;
			$display("mismatch %s %s expected %0h actual %0h", name, field, expVal, actVal);
		end
	endtask

	task automatic compareOutputs(input string name, input expect_t e);
		checkValue(name, "valid", 64'(e.wb.valid), 64'(wbOut.valid));
		if (e.wb.valid)
			checkValue(name, "lane", 64'(e.wb.lane), 64'(wbOut.lane));
		checkValue(name, "data", 64'(e.wb.data), 64'(wbOut.data));   // Held when no read
		checkValue(name, "illegal", 64'(e.illegal), 64'(illegal));
	endtask

	initial begin
		expect_t cur;
		expect_t prev;
		string   prevName;
		int      assertFails;
		rstN = 1'b0;
		memRead = LANE_NONE;
		memWrite = LANE_NONE;
		addr = '0;
		wdata = '0;
		heldData = '0;
		for (int i = 0; i < `MEM_BYTES; i++)
			refMem[i] = 8'h00;
		buildTable();
		cycleLimit = ops.size() + RESET_CYCLES + 20;

		repeat (RESET_CYCLES) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		compareOutputs("afterReset", '0);

		// Op i goes in on one edge, op i-1 is on the outputs by the next negedge
		for (int i = 0; i < ops.size(); i++) begin
			@(posedge clk);
			driveOp(ops[i]);
			predictOp(ops[i], cur);
			@(negedge clk);
			if (i > 0)
				compareOutputs(prevName, prev);
			prev = cur;
			prevName = opNames[i];
		end
		@(posedge clk);
		memRead <= LANE_NONE;
		memWrite <= LANE_NONE;
		@(negedge clk);
		compareOutputs(prevName, prev);

		assertFails = uut.uAssertions.failCount;
		errorCount += assertFails;
		$display("checks %0d, errors %0d, assertion failures %0d",
			checkCount, errorCount, assertFails);
		if (errorCount == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+.
memStagePkg.sv
memLaneSelect.sv
dataMem.sv
memWbReg.sv
memStageTop.sv
memStage_assertions.sv
memStage_tb.sv

// ==== Makefile ====
# Verilator build and run of the memory stage testbench

SIM = obj_dir/VmemStage_tb

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): build.f $(wildcard *.sv *.svh)
	verilator --binary --assert --top-module memStage_tb -f build.f -o VmemStage_tb

# Pass only when the log holds the pass line
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
